//--- address_filter.sv
`timescale 1ns/1ps

module address_filter (
   input  logic        rx_clk,
   input  logic        reset,
   input  logic        go,
   input  logic [7:0]  data,
   input  logic [47:0] address,
   output logic        match
);

   logic [2:0] idx;
   logic [2:0] sel;
   logic [5:0] base;
   logic [7:0] addr_byte;
   logic       busy;
   logic       ok;
   logic       hit;
   logic       byte_eq;
   logic       last;

   // first byte is compared in the go cycle itself
   assign sel       = go ? 3'd0 : idx;
   assign base      = {3'd5 - sel, 3'b000};
   assign addr_byte = address[base +: 8];
   assign byte_eq   = (data == addr_byte);
   assign last      = busy & (idx == 3'd5) & ok & byte_eq;

   // sixth byte decides in its own cycle, then the result is held
   assign match = (hit & ~go) | last;

   always_ff @(posedge rx_clk)
   begin
      if (reset)
      begin
         idx  <= '0;
         busy <= 1'b0;
         ok   <= 1'b0;
         hit  <= 1'b0;
      end
      else if (go)
      begin
         idx  <= 3'd1;
         busy <= 1'b1;
         ok   <= byte_eq;
         hit  <= 1'b0;
      end
      else if (busy)
      begin
         ok <= ok & byte_eq;
         if (idx == 3'd5)
         begin
            busy <= 1'b0;
            hit  <= last;
         end
         else
            idx <= idx + 3'd1;
      end
   end

endmodule

//--- crc_check.sv
`timescale 1ns/1ps

module crc_check (
   input  logic       rx_clk,
   input  logic       reset,
   input  logic       clear,
   input  logic       calc,
   input  logic [7:0] data,
   output logic       match
);

   localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;

   logic [31:0] crc;

   // data enters lsb first as sent on the wire
   function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
      logic [31:0] r;
      r = c;
      for (int i = 0; i < 8; i++)
      begin
         if (r[31] ^ d[i])
            r = {r[30:0], 1'b0} ^ CRC_POLY;
         else
            r = {r[30:0], 1'b0};
      end
      return r;
   endfunction

   always_ff @(posedge rx_clk)
   begin
      if (reset || clear)
         crc <= 32'hFFFF_FFFF;
      else if (calc)
         crc <= crc_byte(crc, data);
   end

   assign match = (crc == gemac_rx_pkg::CRC_RESIDUE);

endmodule

//--- gemac_rx.sv
`timescale 1ns/1ps

module gemac_rx #(
   parameter int DELAY = 6
) (
   input  logic        rx_clk,
   input  logic        reset,
   input  logic        gmii_rx_dv,
   input  logic        gmii_rx_er,
   input  logic [7:0]  gmii_rxd,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [7:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   output logic [7:0]  rx_data,
   output logic        rx_valid,
   output logic        rx_error,
   output logic        rx_ack,
   output logic        pause_rcvd,
   output logic [15:0] pause_quanta
);

   logic       rx_dv_d1;
   logic       rx_er_d1;
   logic [7:0] rxd_d1;
   logic [9:0] rx_del;
   logic       filt_go;
   logic       is_ucast;
   logic       is_mcast;
   logic       is_bcast;
   logic       is_pause;
   logic       crc_clear;
   logic       crc_calc;
   logic       crc_match;
   logic       cnt_clear;
   logic       long_enough;

   rx_filter_cfg_if cfg_if ();

   always_ff @(posedge rx_clk)
   begin
      rx_dv_d1 <= gmii_rx_dv;
      rx_er_d1 <= gmii_rx_er;
      rxd_d1   <= gmii_rxd;
   end

   gemac_rx_regs regs_inst (
      .rx_clk(rx_clk), .reset(reset),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .pause_rcvd(pause_rcvd), .pause_quanta(pause_quanta), .cfg(cfg_if.regs)
   );

   address_filter ucast_filter_inst (
      .rx_clk(rx_clk), .reset(reset), .go(filt_go), .data(rxd_d1),
      .address(cfg_if.ucast_addr), .match(is_ucast)
   );

   address_filter mcast_filter_inst (
      .rx_clk(rx_clk), .reset(reset), .go(filt_go), .data(rxd_d1),
      .address(cfg_if.mcast_addr), .match(is_mcast)
   );

   address_filter bcast_filter_inst (
      .rx_clk(rx_clk), .reset(reset), .go(filt_go), .data(rxd_d1),
      .address(gemac_rx_pkg::BCAST_ADDR), .match(is_bcast)
   );

   address_filter pause_filter_inst (
      .rx_clk(rx_clk), .reset(reset), .go(filt_go), .data(rxd_d1),
      .address(gemac_rx_pkg::PAUSE_ADDR), .match(is_pause)
   );

   crc_check crc_inst (
      .rx_clk(rx_clk), .reset(reset), .clear(crc_clear), .calc(crc_calc),
      .data(rxd_d1), .match(crc_match)
   );

   rx_delay_line #(.DEPTH(DELAY)) delay_inst (
      .rx_clk(rx_clk), .din({rx_dv_d1, rx_er_d1, rxd_d1}), .dout(rx_del)
   );

   assign rx_data = rx_del[7:0];

   rx_frame_counter frame_counter_inst (
      .rx_clk(rx_clk), .reset(reset), .clear(cnt_clear), .long_enough(long_enough)
   );

   gemac_rx_fsm fsm_inst (
      .rx_clk(rx_clk), .reset(reset),
      .rx_dv(rx_dv_d1), .rx_er(rx_er_d1), .rxd(rxd_d1),
      .is_ucast(is_ucast), .is_mcast(is_mcast), .is_bcast(is_bcast), .is_pause(is_pause),
      .crc_match(crc_match), .long_enough(long_enough), .cfg(cfg_if.fsm),
      .filt_go(filt_go), .crc_clear(crc_clear), .crc_calc(crc_calc), .cnt_clear(cnt_clear),
      .rx_valid(rx_valid), .rx_ack(rx_ack), .rx_error(rx_error),
      .pause_rcvd(pause_rcvd), .pause_quanta(pause_quanta)
   );

endmodule

//--- gemac_rx_fsm.sv
`timescale 1ns/1ps

module gemac_rx_fsm (
   input  logic        rx_clk,
   input  logic        reset,
   input  logic        rx_dv,
   input  logic        rx_er,
   input  logic [7:0]  rxd,
   input  logic        is_ucast,
   input  logic        is_mcast,
   input  logic        is_bcast,
   input  logic        is_pause,
   input  logic        crc_match,
   input  logic        long_enough,
   rx_filter_cfg_if.fsm cfg,
   output logic        filt_go,
   output logic        crc_clear,
   output logic        crc_calc,
   output logic        cnt_clear,
   output logic        rx_valid,
   output logic        rx_ack,
   output logic        rx_error,
   output logic        pause_rcvd,
   output logic [15:0] pause_quanta
);

   gemac_rx_pkg::rx_state_t state;
   gemac_rx_pkg::rx_state_t state_next;
   logic [7:0] state_bits;
   logic [4:0] go_pipe;
   logic       decide;
   logic       keep_packet;

   assign state_bits = state;
   // filters finish on the sixth destination byte
   assign decide = go_pipe[4];

   assign keep_packet = (cfg.pass_ucast & is_ucast) | (cfg.pass_mcast & is_mcast) |
                        (cfg.pass_bcast & is_bcast) | (cfg.pass_pause & is_pause) |
                        cfg.pass_all;

   assign crc_clear = (state == gemac_rx_pkg::RX_IDLE);
   assign cnt_clear = (state == gemac_rx_pkg::RX_IDLE);
   assign crc_calc  = (state == gemac_rx_pkg::RX_FRAME) | (state_bits[7:4] == 4'h1);

   always_comb
   begin
      state_next = state;
      if (rx_er)
         state_next = gemac_rx_pkg::RX_ERROR;
      else
         case (state)
            gemac_rx_pkg::RX_IDLE:
               if (rx_dv)
                  state_next = (rxd == gemac_rx_pkg::PREAMBLE_BYTE) ?
                               gemac_rx_pkg::RX_PREAMBLE : gemac_rx_pkg::RX_ERROR;
            gemac_rx_pkg::RX_PREAMBLE:
               if (!rx_dv)
                  state_next = gemac_rx_pkg::RX_ERROR;
               else if (rxd == gemac_rx_pkg::START_BYTE)
                  state_next = gemac_rx_pkg::RX_FRAME;
               else if (rxd != gemac_rx_pkg::PREAMBLE_BYTE)
                  state_next = gemac_rx_pkg::RX_ERROR;
            gemac_rx_pkg::RX_FRAME:
               if (is_pause)
                  state_next = gemac_rx_pkg::RX_PAUSE_SA0;
               else if (!rx_dv)
                  state_next = crc_match ? gemac_rx_pkg::RX_GOOD_FRAME :
                                           gemac_rx_pkg::RX_ERROR;
            // mac control type 8808, then pause opcode 0001
            gemac_rx_pkg::RX_PAUSE_CHK88:
               state_next = (rxd == 8'h88) ? gemac_rx_pkg::RX_PAUSE_CHK08 :
                                             gemac_rx_pkg::RX_DROP;
            gemac_rx_pkg::RX_PAUSE_CHK08:
               state_next = (rxd == 8'h08) ? gemac_rx_pkg::RX_PAUSE_CHK00 :
                                             gemac_rx_pkg::RX_DROP;
            gemac_rx_pkg::RX_PAUSE_CHK00:
               state_next = (rxd == 8'h00) ? gemac_rx_pkg::RX_PAUSE_CHK01 :
                                             gemac_rx_pkg::RX_DROP;
            gemac_rx_pkg::RX_PAUSE_CHK01:
               state_next = (rxd == 8'h01) ? gemac_rx_pkg::RX_PAUSE_STORE_MSB :
                                             gemac_rx_pkg::RX_DROP;
            gemac_rx_pkg::RX_PAUSE_WAIT_CRC:
               if (long_enough)
                  state_next = crc_match ? gemac_rx_pkg::RX_DO_PAUSE :
                                           gemac_rx_pkg::RX_DROP;
            gemac_rx_pkg::RX_GOOD_FRAME,
            gemac_rx_pkg::RX_DO_PAUSE:
               state_next = gemac_rx_pkg::RX_IDLE;
            gemac_rx_pkg::RX_DROP,
            gemac_rx_pkg::RX_ERROR:
               if (!rx_dv)
                  state_next = gemac_rx_pkg::RX_IDLE;
            // source address bytes and quanta stores just step on
            default:
               state_next = gemac_rx_pkg::rx_state_t'(state_bits + 8'd1);
         endcase
   end

   always_ff @(posedge rx_clk)
   begin
      if (reset)
      begin
         state        <= gemac_rx_pkg::RX_IDLE;
         filt_go      <= 1'b0;
         go_pipe      <= '0;
         rx_valid     <= 1'b0;
         rx_ack       <= 1'b0;
         rx_error     <= 1'b0;
         pause_rcvd   <= 1'b0;
         pause_quanta <= '0;
      end
      else
      begin
         state      <= state_next;
         filt_go    <= (state == gemac_rx_pkg::RX_PREAMBLE) &&
                       (state_next == gemac_rx_pkg::RX_FRAME);
         go_pipe    <= {go_pipe[3:0], filt_go};
         rx_ack     <= (state_next == gemac_rx_pkg::RX_GOOD_FRAME);
         rx_error   <= (state_next == gemac_rx_pkg::RX_ERROR);
         pause_rcvd <= (state_next == gemac_rx_pkg::RX_DO_PAUSE);

         // drops before the fcs leaves the delay line
         if ((state_next == gemac_rx_pkg::RX_IDLE) || (state_next == gemac_rx_pkg::RX_ERROR))
            rx_valid <= 1'b0;
         else if (decide && keep_packet)
            rx_valid <= 1'b1;

         if (state == gemac_rx_pkg::RX_PAUSE_STORE_MSB)
            pause_quanta[15:8] <= rxd;
         else if (state == gemac_rx_pkg::RX_PAUSE_STORE_LSB)
            pause_quanta[7:0] <= rxd;
      end
   end

endmodule

//--- gemac_rx_pkg.sv
package gemac_rx_pkg;

   // pause states sit together in the 0x1x code range
   typedef enum logic [7:0] {
      RX_IDLE            = 8'h00,
      RX_PREAMBLE        = 8'h01,
      RX_FRAME           = 8'h02,
      RX_GOOD_FRAME      = 8'h03,
      RX_DO_PAUSE        = 8'h04,
      RX_ERROR           = 8'h05,
      RX_DROP            = 8'h06,
      RX_PAUSE_SA0       = 8'h10,
      RX_PAUSE_SA1       = 8'h11,
      RX_PAUSE_SA2       = 8'h12,
      RX_PAUSE_SA3       = 8'h13,
      RX_PAUSE_SA4       = 8'h14,
      RX_PAUSE_SA5       = 8'h15,
      RX_PAUSE_CHK88     = 8'h16,
      RX_PAUSE_CHK08     = 8'h17,
      RX_PAUSE_CHK00     = 8'h18,
      RX_PAUSE_CHK01     = 8'h19,
      RX_PAUSE_STORE_MSB = 8'h1A,
      RX_PAUSE_STORE_LSB = 8'h1B,
      RX_PAUSE_WAIT_CRC  = 8'h1C
   } rx_state_t;

   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] START_BYTE    = 8'hD5;

   localparam logic [47:0] BCAST_ADDR = 48'hFFFF_FFFF_FFFF;
   localparam logic [47:0] PAUSE_ADDR = 48'h0180_C200_0001;

   // crc register after a good frame including its fcs
   localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;

   // bytes since idle before the pause crc is judged
   localparam logic [15:0] MIN_PAUSE_LEN = 16'd71;

   localparam logic [7:0] REG_UCAST_LO = 8'h00;
   localparam logic [7:0] REG_UCAST_HI = 8'h04;
   localparam logic [7:0] REG_MCAST_LO = 8'h08;
   localparam logic [7:0] REG_MCAST_HI = 8'h0C;
   localparam logic [7:0] REG_PASS     = 8'h10;
   localparam logic [7:0] REG_PAUSE    = 8'h14;

endpackage

//--- gemac_rx_regs.sv
`timescale 1ns/1ps

module gemac_rx_regs (
   input  logic        rx_clk,
   input  logic        reset,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [7:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   input  logic        pause_rcvd,
   input  logic [15:0] pause_quanta,
   rx_filter_cfg_if.regs cfg
);

   logic        access;
   logic        mapped;
   logic [15:0] pause_count;

   assign access = psel & penable;
   // no wait states
   assign pready = 1'b1;

   always_comb
   begin
      mapped = 1'b1;
      prdata = '0;
      case (paddr)
         gemac_rx_pkg::REG_UCAST_LO: prdata = cfg.ucast_addr[31:0];
         gemac_rx_pkg::REG_UCAST_HI: prdata = {16'h0000, cfg.ucast_addr[47:32]};
         gemac_rx_pkg::REG_MCAST_LO: prdata = cfg.mcast_addr[31:0];
         gemac_rx_pkg::REG_MCAST_HI: prdata = {16'h0000, cfg.mcast_addr[47:32]};
         gemac_rx_pkg::REG_PASS:
            prdata = {27'd0, cfg.pass_all, cfg.pass_pause, cfg.pass_bcast,
                      cfg.pass_mcast, cfg.pass_ucast};
         gemac_rx_pkg::REG_PAUSE: prdata = {pause_count, pause_quanta};
         default: mapped = 1'b0;
      endcase
   end

   assign pslverr = access & ~mapped;

   always_ff @(posedge rx_clk)
   begin
      if (reset)
      begin
         cfg.ucast_addr <= '0;
         cfg.mcast_addr <= '0;
         cfg.pass_ucast <= 1'b0;
         cfg.pass_mcast <= 1'b0;
         cfg.pass_bcast <= 1'b0;
         cfg.pass_pause <= 1'b0;
         cfg.pass_all   <= 1'b0;
         pause_count    <= '0;
      end
      else
      begin
         // wraps at 16 bits
         if (pause_rcvd)
            pause_count <= pause_count + 16'd1;
         if (access && pwrite)
         begin
            case (paddr)
               gemac_rx_pkg::REG_UCAST_LO: cfg.ucast_addr[31:0]  <= pwdata;
               gemac_rx_pkg::REG_UCAST_HI: cfg.ucast_addr[47:32] <= pwdata[15:0];
               gemac_rx_pkg::REG_MCAST_LO: cfg.mcast_addr[31:0]  <= pwdata;
               gemac_rx_pkg::REG_MCAST_HI: cfg.mcast_addr[47:32] <= pwdata[15:0];
               gemac_rx_pkg::REG_PASS:
               begin
                  cfg.pass_ucast <= pwdata[0];
                  cfg.pass_mcast <= pwdata[1];
                  cfg.pass_bcast <= pwdata[2];
                  cfg.pass_pause <= pwdata[3];
                  cfg.pass_all   <= pwdata[4];
               end
               default: ;
            endcase
         end
      end
   end

endmodule

//--- gemac_rx_tb.sv
`timescale 1ns/1ps

module gemac_rx_tb;

   typedef logic [7:0] byte_q_t [$];

   localparam logic [47:0] UCAST = 48'h0211_2233_4455;
   localparam logic [47:0] MCAST = 48'h0100_5E00_00FB;
   localparam logic [47:0] OTHER = 48'h0266_7788_99AA;
   localparam logic [47:0] SRC   = 48'h02AA_BBCC_DDEE;

   logic        rx_clk;
   logic        reset;
   logic        gmii_rx_dv;
   logic        gmii_rx_er;
   logic [7:0]  gmii_rxd;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic [7:0]  rx_data;
   logic        rx_valid;
   logic        rx_error;
   logic        rx_ack;
   logic        pause_rcvd;
   logic [15:0] pause_quanta;

   logic [31:0] lcg_state;
   string       tname;
   byte_q_t     frame_q;
   byte_q_t     exp_q;
   byte_q_t     got_q;
   int          ack_count = 0;
   int          err_count = 0;
   int          pause_pulses = 0;
   logic        valid_q = 1'b0;
   logic        ack_q = 1'b0;
   logic        err_q = 1'b0;
   logic        pause_q = 1'b0;
   event        frame_done;

   gemac_rx #(.DELAY(6)) gemac_rx_inst (
      .rx_clk(rx_clk), .reset(reset),
      .gmii_rx_dv(gmii_rx_dv), .gmii_rx_er(gmii_rx_er), .gmii_rxd(gmii_rxd),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .rx_data(rx_data), .rx_valid(rx_valid), .rx_error(rx_error), .rx_ack(rx_ack),
      .pause_rcvd(pause_rcvd), .pause_quanta(pause_quanta)
   );

   initial
   begin
      rx_clk = 1'b0;
      forever #5 rx_clk = ~rx_clk;
   end

   // outputs are sampled mid-cycle
   always @(negedge rx_clk)
   begin
      if (!reset)
      begin
         if (rx_valid)
            got_q.push_back(rx_data);
         else if (valid_q)
            -> frame_done;
         if (rx_ack && !ack_q)
            ack_count++;
         if (rx_error && !err_q)
            err_count++;
         if (pause_rcvd && !pause_q)
            pause_pulses++;
         valid_q = rx_valid;
         ack_q   = rx_ack;
         err_q   = rx_error;
         pause_q = pause_rcvd;
      end
   end

   always @(frame_done)
   begin
      check_value("frame length", exp_q.size(), got_q.size());
      for (int i = 0; i < got_q.size() && i < exp_q.size(); i++)
         check_value($sformatf("frame byte %0d", i), exp_q[i], got_q[i]);
      exp_q.delete();
      got_q.delete();
   end

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string what, input logic [47:0] exp,
                              input logic [47:0] act);
      assert (act === exp)
      else
         report_fail($sformatf("Fail %s %s expected %0h actual %0h", tname, what, exp, act));
   endtask

   task automatic next_cycle();
      @(posedge rx_clk);
      #1;
   endtask

   task automatic quiet(input int n);
      repeat (n) next_cycle();
   endtask

   function automatic logic [7:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[23:16];
   endfunction

   // reflected crc-32 as sent on the wire
   function automatic logic [31:0] crc32_ref(input byte_q_t data);
      logic [31:0] c;
      c = 32'hFFFF_FFFF;
      foreach (data[i])
      begin
         c = c ^ {24'd0, data[i]};
         for (int b = 0; b < 8; b++)
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
      end
      return ~c;
   endfunction

   // flag bits run ucast mcast bcast pause all from bit 0
   function automatic logic keep_ref(input logic [47:0] da, input logic [4:0] flags);
      return (flags[0] && da == UCAST) || (flags[1] && da == MCAST) ||
             (flags[2] && da == gemac_rx_pkg::BCAST_ADDR) ||
             (flags[3] && da == gemac_rx_pkg::PAUSE_ADDR) || flags[4];
   endfunction

   function automatic int event_count(input int which);
      case (which)
         0: return ack_count;
         1: return err_count;
         default: return pause_pulses;
      endcase
   endfunction

   task automatic wait_for(input int which, input int target, input string what);
      int n;
      n = 0;
      while (event_count(which) < target)
      begin
         n++;
         if (n > 400)
            report_fail($sformatf("timeout waiting for %s in test %s", what, tname));
         next_cycle();
      end
   endtask

   task automatic apb_access(input logic write, input logic [7:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      int n;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      next_cycle();
      penable = 1'b1;
      n = 0;
      @(negedge rx_clk);
      while (!pready)
      begin
         n++;
         if (n > 50)
            report_fail($sformatf("timeout waiting for pready in test %s", tname));
         @(negedge rx_clk);
      end
      rdata = prdata;
      err   = pslverr;
      next_cycle();
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] rdata;
      logic        err;
      apb_access(1'b1, addr, data, rdata, err);
      check_value($sformatf("pslverr on write %0h", addr), 0, err);
   endtask

   task automatic apb_check(input string what, input logic [7:0] addr,
                            input logic [31:0] exp);
      logic [31:0] rdata;
      logic        err;
      apb_access(1'b0, addr, 32'd0, rdata, err);
      check_value({what, " pslverr"}, 0, err);
      check_value(what, exp, rdata);
   endtask

   task automatic build_frame(input logic [47:0] da, input logic [15:0] etype, input int plen);
      frame_q.delete();
      for (int i = 5; i >= 0; i--)
         frame_q.push_back(da[i*8 +: 8]);
      for (int i = 5; i >= 0; i--)
         frame_q.push_back(SRC[i*8 +: 8]);
      frame_q.push_back(etype[15:8]);
      frame_q.push_back(etype[7:0]);
      for (int i = 0; i < plen; i++)
         frame_q.push_back(next_random());
   endtask

   // preamble, sfd, frame_q, then fcs low byte first
   task automatic send_frame(input logic corrupt, input int er_idx);
      byte_q_t     wire_q;
      logic [31:0] fcs;
      fcs = crc32_ref(frame_q);
      if (corrupt)
         fcs[7:0] = ~fcs[7:0];
      wire_q = frame_q;
      for (int i = 0; i < 4; i++)
         wire_q.push_back(fcs[i*8 +: 8]);
      for (int i = 0; i < 8; i++)
      begin
         gmii_rx_dv = 1'b1;
         gmii_rxd   = (i == 7) ? gemac_rx_pkg::START_BYTE : gemac_rx_pkg::PREAMBLE_BYTE;
         next_cycle();
      end
      foreach (wire_q[i])
      begin
         gmii_rxd   = wire_q[i];
         gmii_rx_er = (i == er_idx);
         next_cycle();
      end
      gmii_rx_dv = 1'b0;
      gmii_rx_er = 1'b0;
      gmii_rxd   = 8'h00;
   endtask

   task automatic good_frame_test(input logic [47:0] da, input logic [4:0] flags);
      int acks;
      int errs;
      acks = ack_count;
      errs = err_count;
      build_frame(da, 16'h0800, 46);
      if (keep_ref(da, flags))
         exp_q = frame_q;
      send_frame(1'b0, -1);
      wait_for(0, acks + 1, "rx_ack");
      quiet(12);
      check_value($sformatf("rx_ack pulses da %0h", da), acks + 1, ack_count);
      check_value($sformatf("rx_error pulses da %0h", da), errs, err_count);
      check_value($sformatf("missing bytes da %0h", da), 0, exp_q.size());
   endtask

   task automatic error_frame_test(input logic corrupt, input int er_idx);
      int acks;
      int errs;
      acks = ack_count;
      errs = err_count;
      build_frame(UCAST, 16'h0800, 46);
      send_frame(corrupt, er_idx);
      wait_for(1, errs + 1, "rx_error");
      quiet(12);
      check_value("rx_ack pulses", acks, ack_count);
      check_value("rx_error pulses", errs + 1, err_count);
   endtask

   task automatic pause_frame_test(input logic [7:0] opcode_lsb, input logic good,
                                   input int sent_before);
      logic [15:0] quanta;
      int          pauses;
      int          acks;
      pauses = pause_pulses;
      acks   = ack_count;
      quanta = {next_random(), next_random()};
      build_frame(gemac_rx_pkg::PAUSE_ADDR, 16'h8808, 0);
      frame_q.push_back(8'h00);
      frame_q.push_back(opcode_lsb);
      frame_q.push_back(quanta[15:8]);
      frame_q.push_back(quanta[7:0]);
      // pad to the 60-byte minimum
      repeat (42) frame_q.push_back(8'h00);
      send_frame(1'b0, -1);
      if (good)
      begin
         wait_for(2, pauses + 1, "pause_rcvd");
         quiet(4);
         check_value("pause_quanta", quanta, pause_quanta);
         check_value("pause_rcvd pulses", pauses + 1, pause_pulses);
         apb_check("pause status", gemac_rx_pkg::REG_PAUSE,
                   {sent_before[15:0] + 16'd1, quanta});
      end
      else
      begin
         quiet(20);
         check_value("pause_rcvd pulses", pauses, pause_pulses);
      end
      check_value("rx_ack pulses", acks, ack_count);
   endtask

   initial
   begin
      logic [31:0] rdata;
      logic        err;
      logic [4:0]  flags;
      reset      = 1'b1;
      gmii_rx_dv = 1'b0;
      gmii_rx_er = 1'b0;
      gmii_rxd   = 8'h00;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = 8'h00;
      pwdata     = 32'd0;
      lcg_state  = 32'h758;
      tname      = "reset";
      repeat (3) @(posedge rx_clk);
      #1;
      reset = 1'b0;
      next_cycle();

      tname = "apb_regs";
      apb_write(gemac_rx_pkg::REG_UCAST_LO, UCAST[31:0]);
      apb_write(gemac_rx_pkg::REG_UCAST_HI, {16'd0, UCAST[47:32]});
      apb_write(gemac_rx_pkg::REG_MCAST_LO, MCAST[31:0]);
      apb_write(gemac_rx_pkg::REG_MCAST_HI, {16'd0, MCAST[47:32]});
      apb_write(gemac_rx_pkg::REG_PASS, 32'h0000_0015);
      apb_check("ucast_lo", gemac_rx_pkg::REG_UCAST_LO, UCAST[31:0]);
      apb_check("ucast_hi", gemac_rx_pkg::REG_UCAST_HI, {16'd0, UCAST[47:32]});
      apb_check("mcast_lo", gemac_rx_pkg::REG_MCAST_LO, MCAST[31:0]);
      apb_check("mcast_hi", gemac_rx_pkg::REG_MCAST_HI, {16'd0, MCAST[47:32]});
      apb_check("pass flags", gemac_rx_pkg::REG_PASS, 32'h0000_0015);
      apb_access(1'b0, 8'h18, 32'd0, rdata, err);
      check_value("unmapped pslverr", 1, err);
      check_value("unmapped prdata", 0, rdata);

      tname = "unicast";
      apb_write(gemac_rx_pkg::REG_PASS, 32'h0000_0001);
      good_frame_test(UCAST, 5'h01);

      tname = "filter";
      for (int f = 0; f < 4; f++)
      begin
         flags = (f == 0) ? 5'h00 : (5'h01 << (f - 1));
         apb_write(gemac_rx_pkg::REG_PASS, {27'd0, flags});
         good_frame_test(UCAST, flags);
         good_frame_test(MCAST, flags);
         good_frame_test(gemac_rx_pkg::BCAST_ADDR, flags);
      end
      apb_write(gemac_rx_pkg::REG_PASS, 32'h0000_0010);
      good_frame_test(OTHER, 5'h10);

      tname = "bad_fcs";
      apb_write(gemac_rx_pkg::REG_PASS, 32'h0000_0000);
      error_frame_test(1'b1, -1);
      tname = "rx_er";
      error_frame_test(1'b0, 20);

      tname = "pause";
      pause_frame_test(8'h01, 1'b1, 0);
      tname = "pause_bad_opcode";
      pause_frame_test(8'h02, 1'b0, 1);

      $display("Simulation PASSED");
      $finish;
   end

endmodule

//--- rx_delay_line.sv
`timescale 1ns/1ps

module rx_delay_line #(
   parameter int DEPTH = 6
) (
   input  logic       rx_clk,
   input  logic [9:0] din,
   output logic [9:0] dout
);

   logic [9:0] stage [DEPTH];

   always_ff @(posedge rx_clk)
   begin
      stage[0] <= din;
      for (int i = 1; i < DEPTH; i++)
         stage[i] <= stage[i-1];
   end

   assign dout = stage[DEPTH-1];

endmodule

//--- rx_filter_cfg_if.sv
`timescale 1ns/1ps

interface rx_filter_cfg_if;
   logic [47:0] ucast_addr;
   logic [47:0] mcast_addr;
   logic        pass_ucast;
   logic        pass_mcast;
   logic        pass_bcast;
   logic        pass_pause;
   logic        pass_all;

   modport regs (
      output ucast_addr, mcast_addr,
      output pass_ucast, pass_mcast, pass_bcast, pass_pause, pass_all
   );

   modport fsm (
      input pass_ucast, pass_mcast, pass_bcast, pass_pause, pass_all
   );
endinterface

//--- rx_frame_counter.sv
`timescale 1ns/1ps

module rx_frame_counter (
   input  logic rx_clk,
   input  logic reset,
   input  logic clear,
   output logic long_enough
);

   logic [15:0] count;

   always_ff @(posedge rx_clk)
   begin
      if (reset || clear)
         count <= '0;
      // saturate
      else if (count != 16'hFFFF)
         count <= count + 16'd1;
   end

   assign long_enough = (count >= gemac_rx_pkg::MIN_PAUSE_LEN);

endmodule

//--- verilog.f
gemac_rx_pkg.sv
rx_filter_cfg_if.sv
gemac_rx_regs.sv
address_filter.sv
crc_check.sv
rx_delay_line.sv
rx_frame_counter.sv
gemac_rx_fsm.sv
gemac_rx.sv
gemac_rx_tb.sv
